//--- source/fpga_pkg.sv
// shared constants for the meter control core
// register map, status layout, output word fields and mode codes
// modules pull these in with a wildcard import in their header
package fpga_pkg;

  localparam int REG_W      = 32;    // register width
  localparam int ADDR_W     = 7;     // header address field
  localparam int HDR_BITS   = 8;     // write flag + address
  localparam int FRAME_BITS = 40;    // header + one data word

  // register map
  localparam logic [ADDR_W-1:0] ADDR_SPI_MUX = 7'd0;
  localparam logic [ADDR_W-1:0] ADDR_4094    = 7'd1;
  localparam logic [ADDR_W-1:0] ADDR_MODE    = 7'd2;
  localparam logic [ADDR_W-1:0] ADDR_DIRECT  = 7'd3;
  localparam logic [ADDR_W-1:0] ADDR_STATUS  = 7'd4;

  // status word, magic in the low byte, flags above
  localparam int          MAGIC_W      = 8;
  localparam int          FLAGS_W      = 4;
  localparam logic [7:0]  STATUS_MAGIC = 8'hAA;

  localparam int OE_4094_BIT = 0;    // enable bit in reg 1

  // alternate function select
  localparam int               MODE_W       = 3;
  localparam logic [MODE_W-1:0] MODE_DIRECT  = 3'd0;
  localparam logic [MODE_W-1:0] MODE_PATTERN = 3'd3;

  // peripheral spi routing, zero parks the bus
  localparam logic [REG_W-1:0] SPI_MUX_4094 = 32'd1;
  localparam logic [REG_W-1:0] SPI_MUX_DAC  = 32'd2;

  // output word fields, lsb and width
  localparam int LEDS_LSB    = 0;
  localparam int LEDS_W      = 4;
  localparam int MONITOR_LSB = 4;
  localparam int MONITOR_W   = 8;
  localparam int PC_SW_LSB   = 12;
  localparam int PC_SW_W     = 2;
  localparam int AZMUX_LSB   = 14;
  localparam int AZMUX_W     = 4;
  localparam int REFMUX_LSB  = 18;
  localparam int REFMUX_W    = 4;
  localparam int CMPR_LATCH_BIT    = 22;
  localparam int SPI_INTR_BIT      = 23;
  localparam int MEAS_COMPLETE_BIT = 24;
  localparam int OUT_W             = 25;

  localparam int PATTERN_SHIFT = 4;  // low counter bits hidden from pattern

endpackage

//--- source/spi_frame_if.sv
// strobes and data between the spi slave and the register bank
// slave side drives the decoded frame, bank side answers with read data
// plain strobes, no handshake
`timescale 1ns/100ps

interface spi_frame_if import fpga_pkg::*; ();

  logic [ADDR_W-1:0] addr;     // header address
  logic [REG_W-1:0]  wdata;    // last 32 bits shifted in
  logic              wr_stb;   // complete write frame
  logic              hdr_stb;  // header byte done
  logic [REG_W-1:0]  rdata;    // addressed register, stable until next hdr_stb

  modport slave (
    output addr, wdata, wr_stb, hdr_stb,
    input  rdata
  );

  modport bank (
    input  addr, wdata, wr_stb, hdr_stb,
    output rdata
  );

endinterface

//--- source/ctrl_if.sv
// control register contents from the register bank to the pin mux
// all levels, updated whenever a register is written
`timescale 1ns/100ps

interface ctrl_if import fpga_pkg::*; ();

  logic [REG_W-1:0]  spi_mux;  // full routing register
  logic              oe_4094;  // 4094 output enable
  logic [MODE_W-1:0] mode;     // alternate function
  logic [REG_W-1:0]  direct;   // direct drive word

  modport bank (
    output spi_mux, oe_4094, mode, direct
  );

  modport mux (
    input spi_mux, oe_4094, mode, direct
  );

endinterface

//--- source/spi_slave.sv
// spi slave, oversampled in the system clock domain
// sck, ss and sdi pass two-flop synchronizers, edges found one clock later
// frame is an 8 bit header (write flag + address) then 32 data bits, msb first
// sdo shifts the addressed register out during the data bits
`timescale 1ns/100ps

module spi_slave import fpga_pkg::*; (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       sck_i,
  input  logic       ss_i,
  input  logic       sdi_i,
  output logic       sdo_o,
  spi_frame_if.slave frame
);

  logic [2:0]       sync_q1;   // {sck, ss, sdi}
  logic [2:0]       sync_q2;
  logic             sck_s;
  logic             ss_s;
  logic             sdi_s;
  logic             sck_d;     // for edge detect
  logic             ss_d;
  logic             sck_rise;
  logic             sck_fall;
  logic             ss_rise;
  logic [$clog2(FRAME_BITS+1)-1:0] bit_cnt;
  logic             wr_flag;
  logic [REG_W-1:0] rx_shift;
  logic [REG_W-1:0] rx_next;
  logic [REG_W-1:0] tx_shift;

  //////////////////////////////
  // synchronizers

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q1 <= 3'b010;           // ss idles high
      sync_q2 <= 3'b010;
      sck_d   <= 1'b0;
      ss_d    <= 1'b1;
    end else begin
      sync_q1 <= {sck_i, ss_i, sdi_i};
      sync_q2 <= sync_q1;
      sck_d   <= sck_s;
      ss_d    <= ss_s;
    end
  end

  assign {sck_s, ss_s, sdi_s} = sync_q2;

  assign sck_rise = sck_s & ~sck_d & ~ss_s;   // only inside a frame
  assign sck_fall = ~sck_s & sck_d & ~ss_s;
  assign ss_rise  = ss_s & ~ss_d;             // end of frame

  assign rx_next = {rx_shift[REG_W-2:0], sdi_s};

  //////////////////////////////
  // deframing

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bit_cnt       <= '0;
      wr_flag       <= 1'b0;
      frame.addr    <= '0;
      frame.hdr_stb <= 1'b0;
      frame.wr_stb  <= 1'b0;
    end else begin
      frame.hdr_stb <= 1'b0;
      // only an exact 40 bit write frame commits
      frame.wr_stb  <= ss_rise && wr_flag && (bit_cnt == FRAME_BITS);
      if (ss_s) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        if (bit_cnt != '1) begin
          bit_cnt <= bit_cnt + 1'b1;  // saturates on overlong frames
        end
        if (bit_cnt == HDR_BITS - 1) begin
          frame.addr    <= rx_next[ADDR_W-1:0];
          wr_flag       <= rx_next[HDR_BITS-1];
          frame.hdr_stb <= 1'b1;
        end
      end
    end
  end

  // data path, the last 32 bits in are the write word
  always_ff @(posedge clk) begin
    if (sck_rise) begin
      rx_shift <= rx_next;
    end
  end

  assign frame.wdata = rx_shift;

  //////////////////////////////
  // read data out

  // rdata is ready well before the falling edge after the header
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_shift <= '0;
    end else if (ss_s) begin
      tx_shift <= '0;              // sdo low when idle
    end else if (sck_fall) begin
      if (bit_cnt == HDR_BITS) begin
        tx_shift <= frame.rdata;   // msb goes out first
      end else begin
        tx_shift <= {tx_shift[REG_W-2:0], 1'b0};
      end
    end
  end

  assign sdo_o = tx_shift[REG_W-1];

endmodule

//--- source/reg_bank.sv
// register bank behind the spi slave
// four writable control registers plus the read only status word
// writes land on wr_stb, read data is latched on hdr_stb
`timescale 1ns/100ps

module reg_bank import fpga_pkg::*; (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic [FLAGS_W-1:0] hw_flags_i,
  spi_frame_if.bank          frame,
  ctrl_if.bank               ctrl
);

  logic [REG_W-1:0] reg_spi_mux;
  logic [REG_W-1:0] reg_4094;
  logic [REG_W-1:0] reg_mode;
  logic [REG_W-1:0] reg_direct;
  logic [REG_W-1:0] reg_status;
  logic [REG_W-1:0] rd_mux;

  //////////////////////////////
  // writes

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      reg_spi_mux <= '0;           // bus parked
      reg_4094    <= '0;           // 4094 not enabled at start up
      reg_mode    <= '0;           // direct mode
      reg_direct  <= '0;
    end else if (frame.wr_stb) begin
      case (frame.addr)
        ADDR_SPI_MUX: reg_spi_mux <= frame.wdata;
        ADDR_4094:    reg_4094    <= frame.wdata;
        ADDR_MODE:    reg_mode    <= frame.wdata;
        ADDR_DIRECT:  reg_direct  <= frame.wdata;
        default: ;                 // status and unknown, dropped
      endcase
    end
  end

  // magic byte lets the host check the link
  assign reg_status = {{(REG_W-FLAGS_W-MAGIC_W){1'b0}}, hw_flags_i, STATUS_MAGIC};

  //////////////////////////////
  // reads

  always_comb begin
    case (frame.addr)
      ADDR_SPI_MUX: rd_mux = reg_spi_mux;
      ADDR_4094:    rd_mux = reg_4094;
      ADDR_MODE:    rd_mux = reg_mode;
      ADDR_DIRECT:  rd_mux = reg_direct;
      ADDR_STATUS:  rd_mux = reg_status;
      default:      rd_mux = '0;   // unmapped reads zero
    endcase
  end

  // held for the whole data phase
  always_ff @(posedge clk) begin
    if (frame.hdr_stb) begin
      frame.rdata <= rd_mux;
    end
  end

  // control levels out to the pin mux
  assign ctrl.spi_mux = reg_spi_mux;
  assign ctrl.oe_4094 = reg_4094[OE_4094_BIT];
  assign ctrl.mode    = reg_mode[MODE_W-1:0];
  assign ctrl.direct  = reg_direct;

endmodule

//--- source/test_pattern.sv
// free running test pattern for board bring-up
// a counter on every clock, low bits dropped so the leds change visibly
// leds field walks all 16 values once per 256 clocks
`timescale 1ns/100ps

module test_pattern import fpga_pkg::*; (
  input  logic             clk,
  input  logic             rst_n_i,
  output logic [OUT_W-1:0] pattern_o
);

  logic [OUT_W+PATTERN_SHIFT-1:0] count;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;       // wraps
    end
  end

  assign pattern_o = count[OUT_W+PATTERN_SHIFT-1:PATTERN_SHIFT];

endmodule

//--- source/pin_mux.sv
// alternate function pin mux
// picks the output word by mode and registers it onto the pins
// also steers the shared spi pins to the 4094 chain or the dac
// routed spi is combinational from the raw pins
`timescale 1ns/100ps

module pin_mux import fpga_pkg::*; (
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic             sck_i,
  input  logic             sdi_i,
  input  logic             spi_cs2_i,
  input  logic [OUT_W-1:0] pattern_i,
  ctrl_if.mux              ctrl,
  output logic [OUT_W-1:0] out_word_o,
  output logic             glb_spi_clk_o,
  output logic             glb_spi_mosi_o,
  output logic             glb_4094_strobe_o,
  output logic             glb_4094_oe_o,
  output logic             spi_dac_ss_o
);

  logic [OUT_W-1:0] word_sel;
  logic             bus_parked;

  //////////////////////////////
  // output word by mode

  always_comb begin
    case (ctrl.mode)
      MODE_DIRECT:  word_sel = ctrl.direct[OUT_W-1:0];  // host drives every pin
      MODE_PATTERN: word_sel = pattern_i;               // bring-up pattern
      default:      word_sel = '0;                      // unused modes, all low
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_word_o <= '0;
    end else begin
      out_word_o <= word_sel;
    end
  end

  //////////////////////////////
  // peripheral spi routing

  assign bus_parked = (ctrl.spi_mux == '0);

  assign glb_spi_clk_o  = bus_parked ? 1'b1 : sck_i;   // park hi
  assign glb_spi_mosi_o = bus_parked ? 1'b1 : sdi_i;   // park hi

  // strobe active hi, cs2 active lo
  assign glb_4094_strobe_o = (ctrl.spi_mux == SPI_MUX_4094) ? ~spi_cs2_i : 1'b0;

  // dac select active lo
  assign spi_dac_ss_o = (ctrl.spi_mux == SPI_MUX_DAC) ? spi_cs2_i : 1'b1;

  assign glb_4094_oe_o = ctrl.oe_4094;  // lo until host enables

endmodule

//--- source/fpga_top.sv
// top level of the meter control core
// spi register bank plus alternate function pin mux, one clock domain
// plain pins here, interfaces only between the blocks
`timescale 1ns/100ps

module fpga_top import fpga_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n_i,
  // host spi
  input  logic                 sck_i,
  input  logic                 ss_i,
  input  logic                 sdi_i,
  input  logic                 spi_cs2_i,
  output logic                 sdo_o,
  input  logic [FLAGS_W-1:0]   hw_flags_i,
  // mode driven outputs
  output logic [LEDS_W-1:0]    leds_o,
  output logic [MONITOR_W-1:0] monitor_o,
  output logic [PC_SW_W-1:0]   pc_sw_o,
  output logic [AZMUX_W-1:0]   azmux_o,
  output logic [REFMUX_W-1:0]  adc_refmux_o,
  output logic                 adc_cmpr_latch_ctl_o,
  output logic                 spi_interrupt_ctl_o,
  output logic                 meas_complete_o,
  // peripheral spi, 4094 and dac
  output logic                 glb_spi_clk_o,
  output logic                 glb_spi_mosi_o,
  output logic                 glb_4094_strobe_ctl_o,
  output logic                 glb_4094_oe_ctl_o,
  output logic                 spi_dac_ss_o
);

  logic [OUT_W-1:0] pattern;
  logic [OUT_W-1:0] out_word;

  spi_frame_if frame_if ();
  ctrl_if      ctrl_bus ();

  //////////////////////////////
  // register access

  spi_slave u_spi_slave (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .sck_i   (sck_i),
    .ss_i    (ss_i),
    .sdi_i   (sdi_i),
    .sdo_o   (sdo_o),
    .frame   (frame_if.slave)
  );

  reg_bank u_reg_bank (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .hw_flags_i (hw_flags_i),
    .frame      (frame_if.bank),
    .ctrl       (ctrl_bus.bank)
  );

  //////////////////////////////
  // outputs

  test_pattern u_test_pattern (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .pattern_o (pattern)
  );

  pin_mux u_pin_mux (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .sck_i             (sck_i),
    .sdi_i             (sdi_i),
    .spi_cs2_i         (spi_cs2_i),
    .pattern_i         (pattern),
    .ctrl              (ctrl_bus.mux),
    .out_word_o        (out_word),
    .glb_spi_clk_o     (glb_spi_clk_o),
    .glb_spi_mosi_o    (glb_spi_mosi_o),
    .glb_4094_strobe_o (glb_4094_strobe_ctl_o),
    .glb_4094_oe_o     (glb_4094_oe_ctl_o),
    .spi_dac_ss_o      (spi_dac_ss_o)
  );

  // leds and monitor sit lowest, most generic
  assign leds_o               = out_word[LEDS_LSB +: LEDS_W];
  assign monitor_o            = out_word[MONITOR_LSB +: MONITOR_W];
  assign pc_sw_o              = out_word[PC_SW_LSB +: PC_SW_W];
  assign azmux_o              = out_word[AZMUX_LSB +: AZMUX_W];
  assign adc_refmux_o         = out_word[REFMUX_LSB +: REFMUX_W];
  assign adc_cmpr_latch_ctl_o = out_word[CMPR_LATCH_BIT];
  assign spi_interrupt_ctl_o  = out_word[SPI_INTR_BIT];
  assign meas_complete_o      = out_word[MEAS_COMPLETE_BIT];

endmodule

//--- tests/fpga_top_tb.sv
// testbench for the meter control core
// runs the vector file through an spi master model and checks the pins
// inputs change and outputs are sampled on the falling clock edge
`timescale 1ns/100ps

module fpga_top_tb import fpga_pkg::*; ();

  localparam int    CLK_PERIOD = 100;
  localparam int    SCK_HALF   = 4;                   // clocks per sck level
  localparam int    SETTLE     = 10;                  // clocks after ss rises
  localparam string VEC_FILE   = "tests/fpga_top_vectors.txt";

  logic               clk;
  logic               rst_n_i;
  logic               sck_i;
  logic               ss_i;
  logic               sdi_i;
  logic               spi_cs2_i;
  logic               sdo_o;
  logic [3:0]         hw_flags_i;
  logic [3:0]         leds_o;
  logic [7:0]         monitor_o;
  logic [1:0]         pc_sw_o;
  logic [3:0]         azmux_o;
  logic [3:0]         adc_refmux_o;
  logic               adc_cmpr_latch_ctl_o;
  logic               spi_interrupt_ctl_o;
  logic               meas_complete_o;
  logic               glb_spi_clk_o;
  logic               glb_spi_mosi_o;
  logic               glb_4094_strobe_ctl_o;
  logic               glb_4094_oe_ctl_o;
  logic               spi_dac_ss_o;

  byte                op_q[$];                        // parsed vector lines
  logic [ADDR_W-1:0]  addr_q[$];
  logic [REG_W-1:0]   val_q[$];
  bit                 wild_q[$];
  bit                 ops_loaded;
  logic [REG_W-1:0]   rnd_word;                       // random direct word
  logic [REG_W-1:0]   last_spi_mux;                   // shadow of reg 0
  logic [REG_W-1:0]   last_4094;                      // shadow of reg 1

  fpga_top UUT (
    .clk                   (clk),
    .rst_n_i               (rst_n_i),
    .sck_i                 (sck_i),
    .ss_i                  (ss_i),
    .sdi_i                 (sdi_i),
    .spi_cs2_i             (spi_cs2_i),
    .sdo_o                 (sdo_o),
    .hw_flags_i            (hw_flags_i),
    .leds_o                (leds_o),
    .monitor_o             (monitor_o),
    .pc_sw_o               (pc_sw_o),
    .azmux_o               (azmux_o),
    .adc_refmux_o          (adc_refmux_o),
    .adc_cmpr_latch_ctl_o  (adc_cmpr_latch_ctl_o),
    .spi_interrupt_ctl_o   (spi_interrupt_ctl_o),
    .meas_complete_o       (meas_complete_o),
    .glb_spi_clk_o         (glb_spi_clk_o),
    .glb_spi_mosi_o        (glb_spi_mosi_o),
    .glb_4094_strobe_ctl_o (glb_4094_strobe_ctl_o),
    .glb_4094_oe_ctl_o     (glb_4094_oe_ctl_o),
    .spi_dac_ss_o          (spi_dac_ss_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  //////////////////////////////
  // helpers

  // 25 bit word rebuilt from the pins with leds lowest
  function automatic logic [OUT_W-1:0] pin_word();
    return {meas_complete_o, spi_interrupt_ctl_o, adc_cmpr_latch_ctl_o,
            adc_refmux_o, azmux_o, pc_sw_o, monitor_o, leds_o};
  endfunction

  task automatic check_value(input string name, input logic [REG_W-1:0] got,
                             input logic [REG_W-1:0] exp);
    assert (got === exp) else begin
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // one 40 bit mode 0 frame with sdo taken just before each rising sck
  task automatic spi_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                          input logic [REG_W-1:0] wdata, output logic [REG_W-1:0] rdata);
    logic [FRAME_BITS-1:0] tx;
    tx    = {wr, addr, wdata};
    rdata = '0;
    @(negedge clk);
    ss_i = 1'b0;
    for (int i = FRAME_BITS-1; i >= 0; i--) begin
      sck_i = 1'b0;
      sdi_i = tx[i];
      repeat (SCK_HALF) @(negedge clk);
      if (i < REG_W) begin
        rdata = {rdata[REG_W-2:0], sdo_o};           // data phase only
      end
      sck_i = 1'b1;
      repeat (SCK_HALF) @(negedge clk);
    end
    sck_i = 1'b0;
    sdi_i = 1'b0;                                     // idle low so it differs from park
    repeat (SCK_HALF) @(negedge clk);
    ss_i = 1'b1;
    repeat (SETTLE) @(negedge clk);
  endtask

  // routed pins against the routing rule for the last mux value
  task automatic check_routing(input logic cs2);
    logic exp_clk;
    logic exp_mosi;
    logic exp_strobe;
    logic exp_dac_ss;
    @(negedge clk);
    spi_cs2_i = cs2;
    sck_i     = cs2;                                  // ss is high so the slave ignores sck
    sdi_i     = ~cs2;                                 // opposite of sck to catch a swap
    @(negedge clk);
    exp_clk    = (last_spi_mux == 32'd0) ? 1'b1 : sck_i;
    exp_mosi   = (last_spi_mux == 32'd0) ? 1'b1 : sdi_i;
    exp_strobe = (last_spi_mux == 32'd1) ? ~cs2 : 1'b0;
    exp_dac_ss = (last_spi_mux == 32'd2) ? cs2 : 1'b1;
    check_value("glb_spi_clk_o", glb_spi_clk_o, exp_clk);
    check_value("glb_spi_mosi_o", glb_spi_mosi_o, exp_mosi);
    check_value("glb_4094_strobe_ctl_o", glb_4094_strobe_ctl_o, exp_strobe);
    check_value("spi_dac_ss_o", spi_dac_ss_o, exp_dac_ss);
    check_value("glb_4094_oe_ctl_o", glb_4094_oe_ctl_o, last_4094[0]);
    sck_i = 1'b0;                                     // back to idle
    sdi_i = 1'b0;
  endtask

  // leds must walk up by one mod 16 and hit every value
  task automatic check_pattern();
    logic [REG_W-1:0]  unused;
    logic [3:0]        prev;
    logic [3:0]        next_led;
    logic [15:0]       seen;
    spi_xfer(1'b1, ADDR_MODE, 32'd3, unused);
    prev       = leds_o;
    seen       = '0;
    seen[prev] = 1'b1;
    repeat (600) begin
      @(negedge clk);
      if (leds_o !== prev) begin
        next_led = prev + 1'b1;                       // wraps at 16
        check_value("leds_o", leds_o, next_led);
        prev       = leds_o;
        seen[prev] = 1'b1;
      end
    end
    assert (seen == 16'hFFFF) else begin
      $display("pattern mode did not show all 16 led values, seen mask 0x%h", seen);
      $display("TEST FAIL");
      $fatal(1, "pattern incomplete");
    end
  endtask

  task automatic check_reset_state();
    check_value("out_word", pin_word(), '0);
    check_value("glb_spi_clk_o", glb_spi_clk_o, 1'b1);
    check_value("glb_spi_mosi_o", glb_spi_mosi_o, 1'b1);
    check_value("glb_4094_strobe_ctl_o", glb_4094_strobe_ctl_o, 1'b0);
    check_value("glb_4094_oe_ctl_o", glb_4094_oe_ctl_o, 1'b0);
    check_value("spi_dac_ss_o", spi_dac_ss_o, 1'b1);
    check_value("sdo_o", sdo_o, 1'b0);
  endtask

  //////////////////////////////
  // vector file

  task automatic load_vectors();
    int               fd;
    int               n;
    string            line;
    byte              op;
    logic [REG_W-1:0] addr;
    logic [REG_W-1:0] val;
    bit               wild;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      $display("could not open the vector file %s", VEC_FILE);
      $display("TEST FAIL");
      $fatal(1, "no vectors");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 4 || line[0] == "#") begin
        continue;                                     // comment or blank
      end
      wild = 1'b0;
      for (int i = 0; i < line.len(); i++) begin
        if (line[i] == "*") begin
          wild = 1'b1;
        end
      end
      val = '0;
      n   = $sscanf(line, "%c %h %h", op, addr, val);
      if (n != (wild ? 2 : 3)) begin
        $display("malformed vector line: %s", line);
        $display("TEST FAIL");
        $fatal(1, "bad vectors");
      end
      op_q.push_back(op);
      addr_q.push_back(addr[ADDR_W-1:0]);
      val_q.push_back(val);
      wild_q.push_back(wild);
    end
    $fclose(fd);
    ops_loaded = 1'b1;
  endtask

  task automatic run_op(input byte op, input logic [ADDR_W-1:0] addr,
                        input logic [REG_W-1:0] val);
    logic [REG_W-1:0] rd;
    case (op)
      "W": begin
        spi_xfer(1'b1, addr, val, rd);
        if (addr == ADDR_SPI_MUX) begin
          last_spi_mux = val;
        end
        if (addr == ADDR_4094) begin
          last_4094 = val;
        end
      end
      "R": begin
        spi_xfer(1'b0, addr, '0, rd);
        check_value("rdata", rd, val);
      end
      "F": begin
        @(negedge clk);
        hw_flags_i = val[3:0];
        spi_xfer(1'b0, ADDR_STATUS, '0, rd);
        check_value("status", rd, {20'h0, val[3:0], 8'hAA});  // flags over magic
      end
      "O": check_value("out_word", pin_word(), val[OUT_W-1:0]);
      "C": check_routing(val[0]);
      "T": check_pattern();
      default: begin
        $display("unknown operation %c in the vector file", op);
        $display("TEST FAIL");
        $fatal(1, "bad operation");
      end
    endcase
  endtask

  //////////////////////////////
  // main sequence and watchdog

  initial begin
    rst_n_i      = 1'b0;
    sck_i        = 1'b0;
    ss_i         = 1'b1;
    sdi_i        = 1'b0;
    spi_cs2_i    = 1'b1;
    hw_flags_i   = '0;
    ops_loaded   = 1'b0;
    last_spi_mux = '0;
    last_4094    = '0;
    void'($urandom(4));
    rnd_word = $urandom();
    load_vectors();
    repeat (2) @(negedge clk);
    rst_n_i = 1'b1;
    repeat (2) @(negedge clk);
    check_reset_state();
    foreach (op_q[k]) begin
      run_op(op_q[k], addr_q[k], wild_q[k] ? rnd_word : val_q[k]);
    end
    $display("TEST PASS");
    $finish;
  end

  // 50 us per vector line plus 1 ms margin
  initial begin
    longint limit_ns;
    wait (ops_loaded);
    limit_ns = longint'(op_q.size()) * 50_000 + 1_000_000;
    #(limit_ns);
    $display("watchdog expired after %0d ns, the run did not finish", limit_ns);
    $display("TEST FAIL");
    $fatal(1, "timeout");
  end

endmodule

//--- fpga_top.f
source/fpga_pkg.sv
source/spi_frame_if.sv
source/ctrl_if.sv
source/spi_slave.sv
source/reg_bank.sv
source/test_pattern.sv
source/pin_mux.sv
source/fpga_top.sv
tests/fpga_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the fpga_top testbench with verilator, run it, judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f fpga_top.f --top-module fpga_top_tb -o fpga_top_sim

./obj_dir/fpga_top_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- tests/fpga_top_vectors.txt
# op addr value  (W write, R read, F flags, O output word, C cs2 + routing, T pattern)
# value * stands for the random direct word
R 02 00000000
R 55 00000000
W 03 01234567
R 03 01234567
O 00 01234567
W 03 FFFFFFFF
O 00 01FFFFFF
W 03 *
R 03 *
O 00 *
W 02 00000001
R 02 00000001
O 00 00000000
W 02 00000002
O 00 00000000
W 02 00000005
O 00 00000000
W 04 12345678
F 00 00000005
F 00 0000000A
C 00 00000000
C 00 00000001
W 00 00000001
R 00 00000001
C 00 00000000
C 00 00000001
W 00 00000002
C 00 00000000
C 00 00000001
W 01 00000001
R 01 00000001
C 00 00000001
W 01 00000000
C 00 00000000
T 00 00000000
W 02 00000000
O 00 *
